// File: src/rotq_pkg.sv
`default_nettype none

package rotq_pkg;

    // Queue geometry
    localparam int DATA_W = 8;
    localparam int DEPTH  = 8;
    localparam int ADDR_W = 3;
    localparam int CNT_W  = ADDR_W + 1;

    // High pops in a row, with low waiting, before low gets one turn
    localparam int STARVE_LIMIT = 3;
    localparam int STARVE_W     = 2;

    // Kind field encodings
    localparam logic KIND_DATA = 1'b0;
    localparam logic KIND_ROT  = 1'b1;

    // Input word, seen as a data entry or as a rotate command.
    // kind and prio share their positions in both views.
    typedef union packed {
        struct packed {
            logic              kind;
            logic              prio;
            logic [DATA_W-1:0] payload;
        } entry;
        struct packed {
            logic              kind;
            logic              prio;
            logic              dir;
            logic [3:0]        pad;
            logic [ADDR_W-1:0] amount;
        } rot;
    } cmd_word_u;

endpackage

`default_nettype wire

// File: src/rot_queue.sv
`timescale 1ns/100ps
`default_nettype none

module rot_queue
    import rotq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rot_en,
    input  logic [ADDR_W-1:0] rot_amount,
    input  logic              rot_dir,
    input  logic              rd_en,
    output logic [DATA_W-1:0] head,
    output logic              empty,
    output logic              full,
    output logic [CNT_W-1:0]  count
);

    // Storage, left without reset
    logic [DATA_W-1:0] mem [DEPTH];

    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] wr_ptr;
    logic [CNT_W-1:0]  cnt;

    logic              rot_ok;
    logic              wr_ok;
    logic              rd_ok;
    logic [CNT_W-1:0]  rot_shift;
    logic [ADDR_W-1:0] wr_slot;
    logic [DATA_W-1:0] rot_data [DEPTH];

    assign count = cnt;
    assign empty = (cnt == '0);
    assign full  = (cnt == CNT_W'(DEPTH));

    // Head falls through; reads zero when nothing is stored
    assign head = empty ? '0 : mem[rd_ptr];

    // Rotation needs 0 < amount < occupancy
    assign rot_ok = rot_en && (rot_amount != '0) && ({1'b0, rot_amount} < cnt);

    // Write into a full queue is dropped
    assign wr_ok = wr_en && !full;

    // A valid rotation wins over the pop, which is then lost
    assign rd_ok = rd_en && !empty && !rot_ok;

    // Logical index of the new first element.
    // Left by k starts at k, right by k starts at count-k.
    assign rot_shift = rot_dir ? (cnt - {1'b0, rot_amount}) : {1'b0, rot_amount};

    // After a rotation the write pointer becomes the old count
    assign wr_slot = rot_ok ? cnt[ADDR_W-1:0] : wr_ptr;

    // Rotated view of the occupied entries, compacted to slot 0
    for (genvar g = 0; g < DEPTH; g++) begin : g_rot
        logic [CNT_W-1:0]  pos_sum;
        logic [CNT_W-1:0]  logical;
        logic [ADDR_W-1:0] phys;

        // Shift is below count, so a single wrap is enough
        assign pos_sum     = CNT_W'(g) + rot_shift;
        assign logical     = (pos_sum >= cnt) ? (pos_sum - cnt) : pos_sum;
        assign phys        = rd_ptr + logical[ADDR_W-1:0];
        assign rot_data[g] = mem[phys];
    end

    // Storage update
    always_ff @(posedge clk) begin
        if (rot_ok) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (CNT_W'(i) < cnt) begin
                    mem[i] <= rot_data[i];
                end
            end
        end
        // Write slot is outside the rotated range
        if (wr_ok) begin
            mem[wr_slot] <= wr_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (rot_ok) begin
                rd_ptr <= '0;
            end else if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (wr_ok) begin
                wr_ptr <= wr_slot + 1'b1;
            end else if (rot_ok) begin
                wr_ptr <= wr_slot;
            end

            // Simultaneous write and pop leave count as is
            case ({wr_ok, rd_ok})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/egress_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module egress_arbiter
    import rotq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] hi_head,
    input  logic              hi_empty,
    input  logic [DATA_W-1:0] lo_head,
    input  logic              lo_empty,
    input  logic              deq,
    output logic              hi_pop,
    output logic              lo_pop,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              out_prio
);

    // High pops made in a row while low was waiting
    logic [STARVE_W-1:0] starve_cnt;
    logic                starved;
    logic                sel_lo;

    assign starved = (starve_cnt == STARVE_W'(STARVE_LIMIT));

    // Low is chosen when high is empty or low has waited long enough
    assign sel_lo = hi_empty || (starved && !lo_empty);

    assign out_valid = !hi_empty || !lo_empty;
    assign out_data  = sel_lo ? lo_head : hi_head;
    assign out_prio  = !sel_lo;

    // deq is ignored unless a head is presented
    assign hi_pop = deq && out_valid && !sel_lo;
    assign lo_pop = deq && out_valid && sel_lo;

    // Starvation guard counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            starve_cnt <= '0;
        end else if (lo_empty || lo_pop) begin
            starve_cnt <= '0;
        end else if (hi_pop) begin
            // Cannot pass the limit, low is forced once it is reached
            starve_cnt <= starve_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/rotq_top.sv
`timescale 1ns/100ps
`default_nettype none

module rotq_top
    import rotq_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  cmd_word_u         in_word,
    input  logic              deq,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    output logic              out_prio,
    output logic              hi_full,
    output logic              lo_full,
    output logic [CNT_W-1:0]  hi_count,
    output logic [CNT_W-1:0]  lo_count
);

    logic              is_data;
    logic              is_rot;
    logic              is_hi;

    logic [DATA_W-1:0] hi_head;
    logic [DATA_W-1:0] lo_head;
    logic              hi_empty;
    logic              lo_empty;
    logic              hi_pop;
    logic              lo_pop;

    // Word decode, kind and prio are common to both views
    assign is_data = in_valid && (in_word.entry.kind == KIND_DATA);
    assign is_rot  = in_valid && (in_word.entry.kind == KIND_ROT);
    assign is_hi   = in_word.entry.prio;

    rot_queue i_hi_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (is_data && is_hi),
        .wr_data    (in_word.entry.payload),
        .rot_en     (is_rot && is_hi),
        .rot_amount (in_word.rot.amount),
        .rot_dir    (in_word.rot.dir),
        .rd_en      (hi_pop),
        .head       (hi_head),
        .empty      (hi_empty),
        .full       (hi_full),
        .count      (hi_count)
    );

    rot_queue i_lo_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (is_data && !is_hi),
        .wr_data    (in_word.entry.payload),
        .rot_en     (is_rot && !is_hi),
        .rot_amount (in_word.rot.amount),
        .rot_dir    (in_word.rot.dir),
        .rd_en      (lo_pop),
        .head       (lo_head),
        .empty      (lo_empty),
        .full       (lo_full),
        .count      (lo_count)
    );

    // Merge both heads onto the output stream
    egress_arbiter i_egress_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .hi_head   (hi_head),
        .hi_empty  (hi_empty),
        .lo_head   (lo_head),
        .lo_empty  (lo_empty),
        .deq       (deq),
        .hi_pop    (hi_pop),
        .lo_pop    (lo_pop),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_prio  (out_prio)
    );

endmodule

`default_nettype wire

// File: testbench/rotq_props.sv
`timescale 1ns/100ps
`default_nettype none

module rot_queue_props
    import rotq_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              wr_en,
    input logic              rot_en,
    input logic [ADDR_W-1:0] rot_amount,
    input logic              rd_en,
    input logic              empty,
    input logic [CNT_W-1:0]  count,
    input logic [ADDR_W-1:0] rd_ptr,
    input logic [ADDR_W-1:0] wr_ptr
);

    // A rotation that the queue honours
    logic rot_legal;

    assign rot_legal = rot_en && (rot_amount != '0) && ({1'b0, rot_amount} < count);

    // Pointer distance matches occupancy modulo the depth
    a_ptr_distance: assert property (
        @(posedge clk) disable iff (!rst_n) (wr_ptr - rd_ptr) == count[ADDR_W-1:0]
    ) else $error("Queue pointers disagree with count %0d", count);

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) count <= CNT_W'(DEPTH)
    ) else $error("Queue count %0d exceeds the depth", count);

    // Rotation blocks the pop, so only a write may change count
    a_rot_keeps_count: assert property (
        @(posedge clk) disable iff (!rst_n) (rot_legal && !wr_en) |=> $stable(count)
    ) else $error("Queue count changed across a rotation without a write");

    // A lone pop of a stored entry lowers count by one
    a_pop_decrements: assert property (
        @(posedge clk) disable iff (!rst_n)
            (rd_en && !empty && !rot_legal && !wr_en) |=> count == $past(count) - 1'b1
    ) else $error("Queue count did not drop by one after a pop");

endmodule

bind rot_queue rot_queue_props i_rot_queue_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .rot_en     (rot_en),
    .rot_amount (rot_amount),
    .rd_en      (rd_en),
    .empty      (empty),
    .count      (count),
    .rd_ptr     (rd_ptr),
    .wr_ptr     (wr_ptr)
);

`default_nettype wire

// File: testbench/rotq_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rotq_tb
    import rotq_pkg::*;
();

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    cmd_word_u         in_word;
    logic              deq;
    logic              out_valid;
    logic [DATA_W-1:0] out_data;
    logic              out_prio;
    logic              hi_full;
    logic              lo_full;
    logic [CNT_W-1:0]  hi_count;
    logic [CNT_W-1:0]  lo_count;

    // Reference model of both classes
    logic [DATA_W-1:0] hi_q [$];
    logic [DATA_W-1:0] lo_q [$];
    int                starve_m;
    int                errors;
    int                timeouts;

    rotq_top i_rotq_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .deq       (deq),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_prio  (out_prio),
        .hi_full   (hi_full),
        .lo_full   (lo_full),
        .hi_count  (hi_count),
        .lo_count  (lo_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] exp,
                               input logic [CNT_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
        end
    endtask

    function automatic cmd_word_u data_word(input logic prio, input logic [DATA_W-1:0] payload);
        cmd_word_u w;
        w.entry.kind    = KIND_DATA;
        w.entry.prio    = prio;
        w.entry.payload = payload;
        return w;
    endfunction

    function automatic cmd_word_u rot_word(input logic prio, input logic dir, input int amt);
        cmd_word_u w;
        w            = '0;
        w.rot.kind   = KIND_ROT;
        w.rot.prio   = prio;
        w.rot.dir    = dir;
        w.rot.amount = ADDR_W'(amt);
        return w;
    endfunction

    // Low is served when high is empty or the guard has tripped
    function automatic logic model_sel_lo();
        return (hi_q.size() == 0) || (starve_m == STARVE_LIMIT && lo_q.size() != 0);
    endfunction

    task automatic rotate_model(input logic prio, input logic dir, input int amt,
                                output logic done);
        logic [DATA_W-1:0] src [$];
        logic [DATA_W-1:0] res [$];
        int                n;
        int                first;
        if (prio) src = hi_q;
        else src = lo_q;
        n    = src.size();
        done = (amt != 0) && (amt < n);
        if (done) begin
            // Left by k starts at k, right by k starts at n-k
            first = dir ? n - amt : amt;
            for (int i = 0; i < n; i++) begin
                res.push_back(src[(first + i) % n]);
            end
            if (prio) hi_q = res;
            else lo_q = res;
        end
    endtask

    task automatic check_outputs();
        logic exp_valid;
        logic sel_lo;
        exp_valid = (hi_q.size() != 0) || (lo_q.size() != 0);
        sel_lo    = model_sel_lo();
        check_flag("out_valid", exp_valid, out_valid);
        if (exp_valid) begin
            check_data("out_data", sel_lo ? lo_q[0] : hi_q[0], out_data);
            check_flag("out_prio", !sel_lo, out_prio);
        end
        check_count("hi_count", CNT_W'(hi_q.size()), hi_count);
        check_count("lo_count", CNT_W'(lo_q.size()), lo_count);
        check_flag("hi_full", hi_q.size() == DEPTH, hi_full);
        check_flag("lo_full", lo_q.size() == DEPTH, lo_full);
    endtask

    // One clock cycle of stimulus, then model update and full output check
    task automatic drive_cycle(input logic valid, input cmd_word_u w, input logic d);
        logic have;
        logic sel_lo;
        logic hi_pop_m;
        logic lo_pop_m;
        logic lo_was_empty;
        logic hi_was_full;
        logic lo_was_full;
        logic rot_done;
        have         = (hi_q.size() != 0) || (lo_q.size() != 0);
        sel_lo       = model_sel_lo();
        hi_pop_m     = d && have && !sel_lo;
        lo_pop_m     = d && have && sel_lo;
        lo_was_empty = (lo_q.size() == 0);
        hi_was_full  = (hi_q.size() == DEPTH);
        lo_was_full  = (lo_q.size() == DEPTH);
        in_valid = valid;
        in_word  = w;
        deq      = d;
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
        deq      = 1'b0;
        rot_done = 1'b0;
        if (valid && w.rot.kind == KIND_ROT) begin
            rotate_model(w.rot.prio, w.rot.dir, w.rot.amount, rot_done);
        end
        // Honoured rotation swallows the pop of its own queue
        if (hi_pop_m && !(rot_done && w.rot.prio)) void'(hi_q.pop_front());
        if (lo_pop_m && !(rot_done && !w.rot.prio)) void'(lo_q.pop_front());
        if (valid && w.entry.kind == KIND_DATA) begin
            if (w.entry.prio && !hi_was_full) hi_q.push_back(w.entry.payload);
            if (!w.entry.prio && !lo_was_full) lo_q.push_back(w.entry.payload);
        end
        if (lo_was_empty || lo_pop_m) starve_m = 0;
        else if (hi_pop_m) starve_m++;
        check_outputs();
    endtask

    task automatic push(input logic prio);
        drive_cycle(1'b1, data_word(prio, DATA_W'($urandom)), 1'b0);
    endtask

    task automatic wait_valid();
        int n;
        n = 0;
        while (out_valid !== 1'b1 && n < 20) begin
            drive_cycle(1'b0, '0, 1'b0);
            n++;
        end
        if (out_valid !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t: out_valid stayed low for 20 cycles", $time);
        end
    endtask

    task automatic pop_expect(input logic exp_prio);
        wait_valid();
        check_flag("out_prio", exp_prio, out_prio);
        drive_cycle(1'b0, '0, 1'b1);
    endtask

    task automatic test_reset_state();
        check_flag("out_valid", 1'b0, out_valid);
        check_count("hi_count", '0, hi_count);
        check_count("lo_count", '0, lo_count);
        check_flag("hi_full", 1'b0, hi_full);
        check_flag("lo_full", 1'b0, lo_full);
    endtask

    task automatic test_fifo_order();
        repeat (5) push(1'b1);
        repeat (5) pop_expect(1'b1);
        repeat (4) push(1'b0);
        repeat (4) pop_expect(1'b0);
    endtask

    task automatic test_rotations();
        int                amt;
        logic [DATA_W-1:0] exp_head;
        repeat (6) push(1'b1);
        amt      = 1 + ($urandom % 5);
        exp_head = hi_q[amt];
        drive_cycle(1'b1, rot_word(1'b1, 1'b0, amt), 1'b0);
        check_data("out_data", exp_head, out_data);
        repeat (6) pop_expect(1'b1);
        repeat (6) push(1'b0);
        // Ignored rotations keep the order and do not block the pop
        exp_head = lo_q[2];
        drive_cycle(1'b1, rot_word(1'b0, 1'b1, 0), 1'b1);
        drive_cycle(1'b1, rot_word(1'b0, 1'b0, 5), 1'b1);
        drive_cycle(1'b1, rot_word(1'b0, 1'b0, 7), 1'b0);
        check_count("lo_count", CNT_W'(4), lo_count);
        check_data("out_data", exp_head, out_data);
        amt      = 1 + ($urandom % 3);
        exp_head = lo_q[4 - amt];
        drive_cycle(1'b1, rot_word(1'b0, 1'b1, amt), 1'b0);
        check_data("out_data", exp_head, out_data);
        repeat (4) pop_expect(1'b0);
    endtask

    task automatic test_rot_blocks_pop();
        logic [DATA_W-1:0] exp_head;
        repeat (5) push(1'b1);
        exp_head = hi_q[2];
        drive_cycle(1'b1, rot_word(1'b1, 1'b0, 2), 1'b1);
        check_count("hi_count", CNT_W'(5), hi_count);
        check_data("out_data", exp_head, out_data);
        repeat (5) pop_expect(1'b1);
    endtask

    task automatic test_starvation();
        logic pattern [9];
        // Three high pops, one low, three high, one low, then high only
        pattern = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
        repeat (7) push(1'b1);
        repeat (2) push(1'b0);
        for (int i = 0; i < 9; i++) begin
            pop_expect(pattern[i]);
        end
        check_flag("out_valid", 1'b0, out_valid);
    endtask

    task automatic test_full_drop();
        repeat (DEPTH) push(1'b0);
        check_flag("lo_full", 1'b1, lo_full);
        push(1'b0);
        check_count("lo_count", CNT_W'(DEPTH), lo_count);
        repeat (DEPTH) pop_expect(1'b0);
        check_flag("out_valid", 1'b0, out_valid);
        check_flag("lo_full", 1'b0, lo_full);
    endtask

    initial begin
        void'($urandom(9788));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_word  = '0;
        deq      = 1'b0;
        errors   = 0;
        timeouts = 0;
        starve_m = 0;
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        test_reset_state();
        test_fifo_order();
        test_rotations();
        test_rot_blocks_pop();
        test_starvation();
        test_full_drop();
        $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rotq.f
src/rotq_pkg.sv
src/rot_queue.sv
src/egress_arbiter.sv
src/rotq_top.sv
testbench/rotq_props.sv
testbench/rotq_tb.sv
